/* sim.f */
+incdir+verif
verilog/conv3x3_pkg.sv
verilog/line_window.sv
verilog/channel_kernel.sv
verilog/pixel_pack.sv
verilog/conv3x3_top.sv
verif/conv3x3_tb.sv

/* verif/conv3x3_model.svh */
/*
	Reference model for the 3x3 filter testbench, included inside the testbench module.
	img_mem holds the frame being sent, ref_pixel gives the expected output word for a centre.
*/

`ifndef CONV3X3_MODEL_SVH
`define CONV3X3_MODEL_SVH

// frame width matches the DUT line length
localparam int IMG_W = 8;
localparam int MAX_H = 8;

// current frame, row major
conv3x3_pkg::pixel_u img_mem [MAX_H][IMG_W];

// one colour field of a pixel, 0 = red, 1 = green, 2 = blue
function automatic int chan_field(input conv3x3_pkg::pixel_u p, input int ch);
	case (ch)
		0:       return int'(p.rgb.red);
		1:       return int'(p.rgb.green);
		default: return int'(p.rgb.blue);
	endcase
endfunction

// value modulo 2^width, always non-negative
function automatic int mod_width(input int value, input int width);
	int m;
	m = value % (1 << width);
	if (m < 0)
		m += 1 << width;
	return m;
endfunction

// expected filter output for centre (r, c) of img_mem
function automatic conv3x3_pkg::pixel_u ref_pixel(input int r, input int c,
		input int w_corner, input int w_edge, input int w_center);
	conv3x3_pkg::pixel_u res;
	int sum;
	int wt;
	int width;
	res.raw = '0;
	for (int ch = 0; ch < conv3x3_pkg::NUM_CHANNELS; ch++) begin
		sum = 0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				// centre, then the four edges, then corners
				if (dr == 0 && dc == 0)
					wt = w_center;
				else if (dr == 0 || dc == 0)
					wt = w_edge;
				else
					wt = w_corner;
				sum += wt * chan_field(img_mem[r + dr][c + dc], ch);
			end
		end
		width = conv3x3_pkg::CHAN_WIDTHS[ch];
		case (ch)
			0:       res.rgb.red   = 5'(mod_width(sum, width));
			1:       res.rgb.green = 6'(mod_width(sum, width));
			default: res.rgb.blue  = 5'(mod_width(sum, width));
		endcase
	end
	return res;
endfunction

`endif

/* verif/conv3x3_tb.sv */
/*
	Testbench for the streaming 3x3 RGB565 filter.
	Sends random, constant and saturated frames, with and without stalls,
	and compares every output word against the reference model in raster order.
*/

`timescale 1ns/1ps

module conv3x3_tb;

	// corner, edge and centre all contribute
	localparam int W_CORNER = 1;
	localparam int W_EDGE   = 2;
	localparam int W_CENTER = -4;
	localparam int SEED     = 35676;
	// cycles allowed for any single wait
	localparam int LIMIT    = 2000;

	`include "conv3x3_model.svh"

	logic                 clk;
	logic                 reset;
	logic                 in_valid;
	logic                 in_ready;
	conv3x3_pkg::pix_in_t in_pix;
	logic                 out_valid;
	logic                 out_ready;
	conv3x3_pkg::pixel_u  out_pix;

	integer seed;
	integer ready_seed;
	int errors;
	int checks;
	int out_count;
	int cycle_cnt;
	int in_pos;
	int beat22_cycle;
	bit first_out_pending;
	bit check_latency;
	bit gap_mode;
	bit rand_ready;
	bit stall_seen;
	conv3x3_pkg::pixel_u held_pix;
	conv3x3_pkg::pixel_u exp_pix;

	// expected words, raster order
	conv3x3_pkg::pixel_u exp_q [$];

	conv3x3_top #(
		.LINE_LENGTH   (IMG_W),
		.WEIGHT_CORNER (W_CORNER),
		.WEIGHT_EDGE   (W_EDGE),
		.WEIGHT_CENTER (W_CENTER)
	) u_conv3x3_top (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_pix    (in_pix),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_pix   (out_pix)
	);

	always #50 clk = ~clk;

	// sink side, always ready or about 3 in 4 cycles
	always @(posedge clk) begin
		if (rand_ready)
			out_ready <= ($random(ready_seed) & 3) != 0;
		else
			out_ready <= 1'b1;
	end

	// comparing process, samples pre-edge values
	always @(posedge clk) begin
		cycle_cnt++;
		if (!reset) begin
			// position of each accepted input beat
			if (in_valid && in_ready) begin
				in_pos = in_pix.sof ? 0 : in_pos + 1;
				if (in_pos == 2 * IMG_W + 2) begin
					beat22_cycle = cycle_cnt;
					first_out_pending = 1'b1;
				end
			end
			// held word must not move under back-pressure
			if (stall_seen) begin
				checks++;
				assert (out_valid && out_pix.raw == held_pix.raw) else begin
					errors++;
					$display("** Error at %0t ns: out_pix held expected %h actual %h",
						$time, held_pix.raw, out_pix.raw);
				end
			end
			stall_seen = out_valid && !out_ready;
			held_pix = out_pix;
			if (out_valid && out_ready) begin
				out_count++;
				checks++;
				assert (exp_q.size() != 0) else begin
					errors++;
					$display("extra output word %h at %0t ns, nothing left to expect",
						out_pix.raw, $time);
				end
				if (exp_q.size() != 0) begin
					exp_pix = exp_q.pop_front();
					checks++;
					assert (out_pix.raw == exp_pix.raw) else begin
						errors++;
						$display("** Error at %0t ns: out_pix expected %h actual %h",
							$time, exp_pix.raw, out_pix.raw);
					end
				end
				// first result of a stall-free frame
				if (first_out_pending && check_latency) begin
					checks++;
					assert (cycle_cnt - beat22_cycle == 3) else begin
						errors++;
						$display("first output came %0d cycles after pixel (2, 2), not 3",
							cycle_cnt - beat22_cycle);
					end
				end
				first_out_pending = 1'b0;
			end
		end
	end

	// closing line and verdict
	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	task automatic timeout_fail(input string what);
		errors++;
		$display("timeout after %0d cycles waiting for %s", LIMIT, what);
		finish_run();
	endtask

	task automatic fill_random(input int h);
		for (int r = 0; r < h; r++)
			for (int c = 0; c < IMG_W; c++)
				img_mem[r][c].raw = 16'($random(seed));
	endtask

	task automatic fill_const(input int h, input logic [15:0] k);
		for (int r = 0; r < h; r++)
			for (int c = 0; c < IMG_W; c++)
				img_mem[r][c].raw = k;
	endtask

	// full white or one channel at its maximum, by address
	task automatic fill_max(input int h);
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < IMG_W; c++) begin
				img_mem[r][c].raw = '0;
				case ((r * IMG_W + c + r) % 4)
					0:       img_mem[r][c].raw = 16'hffff;
					1:       img_mem[r][c].rgb.red = 5'd31;
					2:       img_mem[r][c].rgb.green = 6'd63;
					default: img_mem[r][c].rgb.blue = 5'd31;
				endcase
			end
		end
	endtask

	// interior centres only
	task automatic queue_expected(input int h);
		for (int r = 1; r < h - 1; r++)
			for (int c = 1; c < IMG_W - 1; c++)
				exp_q.push_back(ref_pixel(r, c, W_CORNER, W_EDGE, W_CENTER));
	endtask

	// number of interior centres in a frame of h lines
	function automatic int interior_count(input int h);
		return (h - 2) * (IMG_W - 2);
	endfunction

	// Laplacian of a flat frame is zero in every channel
	task automatic check_laplacian(input int h);
		conv3x3_pkg::pixel_u lap;
		for (int r = 1; r < h - 1; r++) begin
			for (int c = 1; c < IMG_W - 1; c++) begin
				lap = ref_pixel(r, c, 0, 1, -4);
				checks++;
				assert (lap.raw == 16'h0000) else begin
					errors++;
					$display("** Error at %0t ns: model laplacian expected %h actual %h",
						$time, 16'h0000, lap.raw);
				end
			end
		end
	endtask

	// one beat, held until in_ready is seen
	task automatic drive_pixel(input conv3x3_pkg::pix_in_t beat);
		int idle;
		int t;
		idle = gap_mode ? int'($unsigned($random(seed)) % 3) : 0;
		for (int i = 0; i < idle; i++) begin
			in_valid <= 1'b0;
			@(posedge clk);
		end
		in_valid <= 1'b1;
		in_pix <= beat;
		t = 0;
		do begin
			@(posedge clk);
			t++;
		end while (!in_ready && t < LIMIT);
		if (!in_ready)
			timeout_fail("in_ready");
	endtask

	task automatic send_frame(input int h);
		conv3x3_pkg::pix_in_t beat;
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < IMG_W; c++) begin
				beat.sof = (r == 0 && c == 0);
				beat.data = img_mem[r][c];
				drive_pixel(beat);
			end
		end
	endtask

	// until every expected word has come out
	task automatic wait_drain();
		int t;
		in_valid <= 1'b0;
		t = 0;
		while (exp_q.size() != 0 && t < LIMIT) begin
			@(posedge clk);
			t++;
		end
		if (exp_q.size() != 0)
			timeout_fail("the remaining output words");
	endtask

	// pipe settles first so a stray word is counted too
	task automatic check_count(input int first, input int expected);
		repeat (6) @(posedge clk);
		checks++;
		assert (out_count - first == expected) else begin
			errors++;
			$display("frame gave %0d outputs instead of %0d", out_count - first, expected);
		end
	endtask

	initial begin
		int start;
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_pix = '0;
		out_ready = 1'b1;
		seed = SEED;
		ready_seed = SEED;
		errors = 0;
		checks = 0;
		out_count = 0;
		cycle_cnt = 0;
		in_pos = 0;
		beat22_cycle = 0;
		first_out_pending = 1'b0;
		check_latency = 1'b0;
		gap_mode = 1'b0;
		rand_ready = 1'b0;
		stall_seen = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// idle after reset
		repeat (4) begin
			@(posedge clk);
			checks++;
			assert (in_ready && !out_valid) else begin
				errors++;
				$display("after reset in_ready is %b and out_valid is %b", in_ready, out_valid);
			end
		end

		// random frame, no stalls, latency checked
		check_latency = 1'b1;
		start = out_count;
		fill_random(6);
		queue_expected(6);
		send_frame(6);
		wait_drain();
		check_count(start, interior_count(6));
		check_latency = 1'b0;

		// flat frame, wraps in all three lanes
		fill_const(6, 16'h6b4d);
		check_laplacian(6);
		queue_expected(6);
		send_frame(6);
		wait_drain();

		// saturated channels, field placement
		fill_max(6);
		queue_expected(6);
		send_frame(6);
		wait_drain();

		// input gaps and random back-pressure
		gap_mode = 1'b1;
		rand_ready = 1'b1;
		start = out_count;
		fill_random(6);
		queue_expected(6);
		send_frame(6);
		wait_drain();
		gap_mode = 1'b0;
		rand_ready = 1'b0;
		check_count(start, interior_count(6));

		// two frames back to back, second one shorter
		start = out_count;
		fill_random(6);
		queue_expected(6);
		send_frame(6);
		fill_random(5);
		queue_expected(5);
		send_frame(5);
		wait_drain();
		check_count(start, interior_count(6) + interior_count(5));

		// room for any stray word to show up
		repeat (6) @(posedge clk);
		finish_run();
	end

endmodule

/* verilog/channel_kernel.sv */
/*
	One colour lane of the 3x3 filter.
	Takes its field from all nine window pixels, applies the symmetric
	corner / edge / centre weights and registers the sum modulo 2^CHAN_WIDTH.
*/

`timescale 1ns/1ps

module channel_kernel #(
	parameter int CHAN_SEL      = 0,
	parameter int CHAN_WIDTH    = 5,
	parameter int WEIGHT_CORNER = 0,
	parameter int WEIGHT_EDGE   = 1,
	parameter int WEIGHT_CENTER = -4
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 adv,
	input  conv3x3_pkg::window_t win,
	input  logic                 win_valid,
	output conv3x3_pkg::chan_t   lane_val,
	output logic                 lane_valid
);

	// int weights times small sums stay well inside 32 bits
	localparam int SUM_WIDTH = 32;

	typedef logic signed [SUM_WIDTH-1:0] sum_t;

	sum_t corner_sum;
	sum_t edge_sum;
	sum_t center_val;
	sum_t total;

	// this lane's field of one pixel, zero-extended
	function automatic conv3x3_pkg::chan_t pick(conv3x3_pkg::pixel_u p);
		conv3x3_pkg::chan_t c;
		case (CHAN_SEL)
			0:       c = conv3x3_pkg::chan_t'(p.rgb.red);
			1:       c = conv3x3_pkg::chan_t'(p.rgb.green);
			default: c = conv3x3_pkg::chan_t'(p.rgb.blue);
		endcase
		return c;
	endfunction

	// symmetric kernel, one weight per ring position
	always_comb begin
		corner_sum = sum_t'(pick(win.top_left)) + sum_t'(pick(win.top_right))
			+ sum_t'(pick(win.bot_left)) + sum_t'(pick(win.bot_right));
		edge_sum = sum_t'(pick(win.top)) + sum_t'(pick(win.mid_left))
			+ sum_t'(pick(win.mid_right)) + sum_t'(pick(win.bot));
		center_val = sum_t'(pick(win.center));
		total = WEIGHT_CORNER * corner_sum + WEIGHT_EDGE * edge_sum
			+ WEIGHT_CENTER * center_val;
	end

	// valid flag
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			lane_valid <= 1'b0;
		else if (adv)
			lane_valid <= win_valid;
	end

	// low bits only, negative sums wrap
	always_ff @(posedge clk) begin
		if (adv)
			lane_val <= conv3x3_pkg::chan_t'(total[CHAN_WIDTH-1:0]);
	end

endmodule

/* verilog/conv3x3_pkg.sv */
/*
	Shared types and constants for the streaming 3x3 RGB565 convolution filter.
	Holds the pixel union, the input beat and window structs and the lane result type.
	Every RTL file refers to these by scoped name.
*/

package conv3x3_pkg;

	// one RGB565 word
	localparam int PIXEL_WIDTH = 16;

	// red, green, blue lanes
	localparam int NUM_CHANNELS = 3;

	// green is the widest field
	localparam int CHAN_MAX_WIDTH = 6;

	// lane widths, index 0 = red, 1 = green, 2 = blue
	localparam int CHAN_WIDTHS [NUM_CHANNELS] = '{5, 6, 5};

	// colour fields, red in the top bits
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb_t;

	// raw word for storage, rgb view for the lanes
	typedef union packed {
		logic [PIXEL_WIDTH-1:0] raw;
		rgb_t rgb;
	} pixel_u;

	// input beat
	// sof marks the first pixel of a frame
	typedef struct packed {
		logic sof;
		pixel_u data;
	} pix_in_t;

	// 3x3 neighbourhood
	// top row is the oldest line, right column the newest pixel
	typedef struct packed {
		pixel_u top_left;
		pixel_u top;
		pixel_u top_right;
		pixel_u mid_left;
		pixel_u center;
		pixel_u mid_right;
		pixel_u bot_left;
		pixel_u bot;
		pixel_u bot_right;
	} window_t;

	// one lane result, 5-bit lanes sit zero-extended in the low bits
	typedef logic [CHAN_MAX_WIDTH-1:0] chan_t;

endpackage

/* verilog/conv3x3_top.sv */
/*
	Streaming 3x3 convolution on RGB565 video, valid/ready in and out.
	Window former, one kernel lane per colour, output packer.
	Emits (H-2)*(W-2) results per frame, three cycles after the last pixel needed.
*/

`timescale 1ns/1ps

module conv3x3_top #(
	parameter int LINE_LENGTH   = 720,
	// default kernel is the Laplacian
	parameter int WEIGHT_CORNER = 0,
	parameter int WEIGHT_EDGE   = 1,
	parameter int WEIGHT_CENTER = -4
) (
	input  logic                 clk,
	input  logic                 reset,

	// pixel stream in
	input  logic                 in_valid,
	output logic                 in_ready,
	input  conv3x3_pkg::pix_in_t in_pix,

	// filtered stream out
	output logic                 out_valid,
	input  logic                 out_ready,
	output conv3x3_pkg::pixel_u  out_pix
);

	// global pipeline enable from the output stage
	logic adv;

	conv3x3_pkg::window_t win;
	logic win_valid;

	// one result and one valid per lane
	conv3x3_pkg::chan_t lane_val [conv3x3_pkg::NUM_CHANNELS];
	logic [conv3x3_pkg::NUM_CHANNELS-1:0] lane_valid;

	// input taken whenever the pipe moves
	assign in_ready = adv;

	line_window #(
		.LINE_LENGTH(LINE_LENGTH)
	) u_line_window (
		.clk       (clk),
		.reset     (reset),
		.adv       (adv),
		.in_valid  (in_valid),
		.in_pix    (in_pix),
		.win       (win),
		.win_valid (win_valid)
	);

	// one lane per colour, width from the channel table
	for (genvar i = 0; i < conv3x3_pkg::NUM_CHANNELS; i++) begin : g_lane
		channel_kernel #(
			.CHAN_SEL      (i),
			.CHAN_WIDTH    (conv3x3_pkg::CHAN_WIDTHS[i]),
			.WEIGHT_CORNER (WEIGHT_CORNER),
			.WEIGHT_EDGE   (WEIGHT_EDGE),
			.WEIGHT_CENTER (WEIGHT_CENTER)
		) u_channel_kernel (
			.clk        (clk),
			.reset      (reset),
			.adv        (adv),
			.win        (win),
			.win_valid  (win_valid),
			.lane_val   (lane_val[i]),
			.lane_valid (lane_valid[i])
		);
	end

	// lanes run in lockstep, lane 0 valid stands for all
	pixel_pack u_pixel_pack (
		.clk        (clk),
		.reset      (reset),
		.lane_val   (lane_val),
		.lane_valid (lane_valid[0]),
		.out_ready  (out_ready),
		.adv        (adv),
		.out_valid  (out_valid),
		.out_pix    (out_pix)
	);

endmodule

/* verilog/line_window.sv */
/*
	Builds the 3x3 neighbourhood from a raster pixel stream.
	Two line buffers hold the previous two lines, a 3x3 register holds the window.
	win_valid marks windows whose centre is an interior pixel.
*/

`timescale 1ns/1ps

module line_window #(
	parameter int LINE_LENGTH = 720
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 adv,
	input  logic                 in_valid,
	input  conv3x3_pkg::pix_in_t in_pix,
	output conv3x3_pkg::window_t win,
	output logic                 win_valid
);

	localparam int COL_WIDTH = (LINE_LENGTH > 1) ? $clog2(LINE_LENGTH) : 1;
	localparam logic [COL_WIDTH-1:0] LAST_COL = COL_WIDTH'(LINE_LENGTH - 1);

	// line_buf1 holds the line above, line_buf2 the one above that
	conv3x3_pkg::pixel_u line_buf1 [LINE_LENGTH];
	conv3x3_pkg::pixel_u line_buf2 [LINE_LENGTH];

	logic [COL_WIDTH-1:0] col_cnt;
	logic [COL_WIDTH-1:0] cur_col;
	// saturates at 2, meaning row 2 or later
	logic [1:0] row_cnt;
	logic [1:0] cur_row;
	logic accept;
	conv3x3_pkg::pixel_u above1;
	conv3x3_pkg::pixel_u above2;

	// beat transfers only while the pipe moves
	assign accept = adv & in_valid;

	// sof forces position (0, 0) for this beat
	assign cur_col = in_pix.sof ? '0 : col_cnt;
	assign cur_row = in_pix.sof ? '0 : row_cnt;

	// same column, one and two lines up
	assign above1 = line_buf1[cur_col];
	assign above2 = line_buf2[cur_col];

	// position counters and the interior flag
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			col_cnt   <= '0;
			row_cnt   <= '0;
			win_valid <= 1'b0;
		end else begin
			if (accept) begin
				// wrap at end of line
				col_cnt <= (cur_col == LAST_COL) ? '0 : cur_col + 1'b1;
				if (cur_col == LAST_COL && cur_row != 2'd2)
					row_cnt <= cur_row + 2'd1;
				else
					row_cnt <= cur_row;
			end
			// held while stalled
			if (adv) begin
				// interior centre at (row-1, col-1)
				win_valid <= in_valid && (cur_row == 2'd2) && (cur_col >= COL_WIDTH'(2));
			end
		end
	end

	// window shift and line buffer update, on accepted beats only
	always_ff @(posedge clk) begin
		if (accept) begin
			// left and middle columns move one step left
			win.top_left <= win.top;
			win.top      <= win.top_right;
			win.mid_left <= win.center;
			win.center   <= win.mid_right;
			win.bot_left <= win.bot;
			win.bot      <= win.bot_right;

			// new right column, oldest line on top
			win.top_right <= above2;
			win.mid_right <= above1;
			win.bot_right <= in_pix.data;

			// lines move down one buffer
			line_buf2[cur_col] <= above1;
			line_buf1[cur_col] <= in_pix.data;
		end
	end

endmodule

/* verilog/pixel_pack.sv */
/*
	Output stage of the filter.
	Packs the three lane results into one RGB565 word and holds it until taken.
	adv is the pipeline enable for every stage and the input ready.
*/

`timescale 1ns/1ps

module pixel_pack (
	input  logic                clk,
	input  logic                reset,
	input  conv3x3_pkg::chan_t  lane_val [conv3x3_pkg::NUM_CHANNELS],
	input  logic                lane_valid,
	input  logic                out_ready,
	output logic                adv,
	output logic                out_valid,
	output conv3x3_pkg::pixel_u out_pix
);

	// move when the output slot is empty or being taken
	assign adv = ~out_valid | out_ready;

	// output valid
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			out_valid <= 1'b0;
		else if (adv)
			out_valid <= lane_valid;
	end

	// field placement through the rgb view
	// lane 0 red, lane 1 green, lane 2 blue
	always_ff @(posedge clk) begin
		if (adv && lane_valid) begin
			out_pix.rgb.red   <= lane_val[0][conv3x3_pkg::CHAN_WIDTHS[0]-1:0];
			out_pix.rgb.green <= lane_val[1][conv3x3_pkg::CHAN_WIDTHS[1]-1:0];
			out_pix.rgb.blue  <= lane_val[2][conv3x3_pkg::CHAN_WIDTHS[2]-1:0];
		end
	end

endmodule
